// ==== src/sevenseg_pkg.sv ====
package sevenseg_pkg;

    // Four packed hex digits, digit 0 in the lowest nibble
    typedef logic [15:0] hex_word_t;

    // One hex digit
    typedef logic [3:0] nibble_t;

    // Segment pattern, bit 0 = a ... bit 6 = g, low-active
    typedef logic [6:0] seg_t;

    // Anode select, bit n = digit n, low-active
    typedef logic [3:0] anode_t;

    // Scan position
    typedef logic [1:0] digit_sel_t;

    // Host register bus
    typedef logic [1:0]  reg_addr_t;
    typedef logic [15:0] reg_data_t;

    // Register map
    localparam reg_addr_t addr_value   = 2'd0;  // Value to show
    localparam reg_addr_t addr_enable  = 2'd1;  // Per-digit enable mask
    localparam reg_addr_t addr_divider = 2'd2;  // Scan divider
    // Address 3 is unused: reads as zero, writes are dropped

    // All segments off
    localparam seg_t seg_blank = 7'b1111111;

    // No digit selected
    localparam anode_t anode_off = 4'b1111;

endpackage

// ==== src/display_regs.sv ====
`timescale 1ns/1ps

module display_regs #(
    parameter int DIV_WIDTH = 16,
    parameter int RESET_DIV = 1000
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  wr_en,
    input  logic                  rd_en,
    input  sevenseg_pkg::reg_addr_t addr,
    input  sevenseg_pkg::reg_data_t wdata,
    output sevenseg_pkg::reg_data_t rdata,
    output logic                  rd_valid,
    output sevenseg_pkg::hex_word_t value,
    output logic [3:0]            digit_en,
    output logic [DIV_WIDTH-1:0]  divider
);

    import sevenseg_pkg::*;

    hex_word_t            value_q;
    logic [3:0]           enable_q;
    logic [DIV_WIDTH-1:0] divider_q;

    reg_data_t            read_mux;
    reg_data_t            rdata_q;
    logic                 rd_valid_q;

    // Configuration registers
    always_ff @(posedge clk) begin
        if (rst) begin
            value_q   <= '0;
            enable_q  <= 4'b1111;  // All digits on after reset
            divider_q <= DIV_WIDTH'(RESET_DIV);
        end else if (wr_en) begin
            case (addr)
                addr_value: begin
                    value_q <= wdata;
                end
                addr_enable: begin
                    enable_q <= wdata[3:0];
                end
                addr_divider: begin
                    divider_q <= DIV_WIDTH'(wdata);  // Keep low DIV_WIDTH bits
                end
                default: begin
                    // Unmapped address, write dropped
                end
            endcase
        end
    end

    // Read decode, upper bits of narrow registers come back as zero
    always_comb begin
        case (addr)
            addr_value:   read_mux = value_q;
            addr_enable:  read_mux = reg_data_t'(enable_q);
            addr_divider: read_mux = reg_data_t'(divider_q);
            default:      read_mux = '0;
        endcase
    end

    // Read data lands one cycle after the strobe.
    // A write in the same cycle is not yet visible here, so the old value returns.
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rdata_q <= read_mux;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= rd_en;  // Single-cycle pulse per read
        end
    end

    assign rdata    = rdata_q;
    assign rd_valid = rd_valid_q;

    assign value    = value_q;
    assign digit_en = enable_q;
    assign divider  = divider_q;

endmodule

// ==== src/hex_display.sv ====
`timescale 1ns/1ps

module hex_display #(
    parameter int DIV_WIDTH = 16
) (
    input  logic                    clk,
    input  logic                    rst,
    input  sevenseg_pkg::hex_word_t value,
    input  logic [3:0]              digit_en,
    input  logic [DIV_WIDTH-1:0]    divider,
    output sevenseg_pkg::seg_t      seg,
    output sevenseg_pkg::anode_t    an
);

    import sevenseg_pkg::*;

    logic [DIV_WIDTH-1:0] presc;
    logic                 presc_wrap;
    digit_sel_t           pos;

    nibble_t              cur_nibble;
    logic                 cur_enabled;
    seg_t                 seg_next;
    anode_t               an_next;

    seg_t                 seg_q;
    anode_t               an_q;

    // Low-active hex font, bit 0 = a through bit 6 = g
    function automatic seg_t hex_font(input nibble_t hex);
        seg_t pattern;
        case (hex)
            4'h0: pattern = 7'b1000000;
            4'h1: pattern = 7'b1111001;
            4'h2: pattern = 7'b0100100;
            4'h3: pattern = 7'b0110000;
            4'h4: pattern = 7'b0011001;
            4'h5: pattern = 7'b0010010;
            4'h6: pattern = 7'b0000010;
            4'h7: pattern = 7'b1111000;
            4'h8: pattern = 7'b0000000;
            4'h9: pattern = 7'b0010000;
            4'hA: pattern = 7'b0001000;
            4'hB: pattern = 7'b0000011;
            4'hC: pattern = 7'b1000110;
            4'hD: pattern = 7'b0100001;
            4'hE: pattern = 7'b0000110;
            4'hF: pattern = 7'b0001110;
            default: pattern = seg_blank;
        endcase
        return pattern;
    endfunction

    // Compare with >= so a smaller divider written mid-dwell still wraps
    assign presc_wrap = (presc >= divider);

    // Prescaler, runs 0..divider then wraps
    always_ff @(posedge clk) begin
        if (rst) begin
            presc <= '0;
        end else if (presc_wrap) begin
            presc <= '0;
        end else begin
            presc <= presc + 1'b1;
        end
    end

    // Scan position, 0 -> 1 -> 2 -> 3 -> 0
    always_ff @(posedge clk) begin
        if (rst) begin
            pos <= '0;  // Digit 0 comes up first
        end else if (presc_wrap) begin
            pos <= pos + 1'b1;
        end
    end

    // Digit select and decode
    assign cur_nibble  = value[{pos, 2'b00} +: 4];
    assign cur_enabled = digit_en[pos];

    always_comb begin
        if (cur_enabled) begin
            seg_next = hex_font(cur_nibble);
        end else begin
            seg_next = seg_blank;  // Blanked digit
        end
    end

    // Anode stays driven for a blanked digit, keeps the scan period even
    assign an_next = ~(anode_t'(4'b0001) << pos);

    // Output registers, anode and segments move on the same edge
    always_ff @(posedge clk) begin
        if (rst) begin
            an_q  <= anode_off;
            seg_q <= seg_blank;
        end else begin
            an_q  <= an_next;
            seg_q <= seg_next;
        end
    end

    assign an  = an_q;
    assign seg = seg_q;

endmodule

// ==== src/display_top.sv ====
`timescale 1ns/1ps

module display_top #(
    parameter int DIV_WIDTH = 16,
    parameter int RESET_DIV = 1000
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    wr_en,
    input  logic                    rd_en,
    input  sevenseg_pkg::reg_addr_t addr,
    input  sevenseg_pkg::reg_data_t wdata,
    output sevenseg_pkg::reg_data_t rdata,
    output logic                    rd_valid,
    output sevenseg_pkg::seg_t      seg,
    output sevenseg_pkg::anode_t    an
);

    import sevenseg_pkg::*;

    // Configuration levels from the register block to the scanner
    hex_word_t            value_w;
    logic [3:0]           digit_en_w;
    logic [DIV_WIDTH-1:0] divider_w;

    display_regs #(
        .DIV_WIDTH (DIV_WIDTH),
        .RESET_DIV (RESET_DIV)
    ) u_regs (
        .clk      (clk),
        .rst      (rst),
        .wr_en    (wr_en),
        .rd_en    (rd_en),
        .addr     (addr),
        .wdata    (wdata),
        .rdata    (rdata),
        .rd_valid (rd_valid),
        .value    (value_w),
        .digit_en (digit_en_w),
        .divider  (divider_w)
    );

    // Free-running scanner
    hex_display #(
        .DIV_WIDTH (DIV_WIDTH)
    ) u_display (
        .clk      (clk),
        .rst      (rst),
        .value    (value_w),
        .digit_en (digit_en_w),
        .divider  (divider_w),
        .seg      (seg),
        .an       (an)
    );

endmodule

// ==== tests/display_assert.sv ====
`timescale 1ns/1ps

module display_assert (
    input logic                 clk,
    input logic                 rst,
    input sevenseg_pkg::seg_t   seg,
    input sevenseg_pkg::anode_t an
);

    import sevenseg_pkg::*;

    // At most one digit driven at a time
    anode_one_cold: assert property (
        @(posedge clk) disable iff (rst) $onehot0(~an)
    ) else $error("More than one anode driven low: %b", an);

    // Outputs dark while reset is applied
    reset_dark: assert property (
        @(posedge clk) rst |=> (an == 4'b1111 && seg == 7'b1111111)
    ) else $error("Display not dark during reset, an %b seg %b", an, seg);

    // Scanning starts right after reset
    scan_starts: assert property (
        @(posedge clk) $fell(rst) |-> ##2 (an != 4'b1111)
    ) else $error("No digit selected two cycles after reset");

endmodule

bind hex_display display_assert u_assert (
    .clk (clk),
    .rst (rst),
    .seg (seg),
    .an  (an)
);

// ==== tests/display_tb.sv ====
`timescale 1ns/1ps

module display_tb;

    import sevenseg_pkg::*;

    localparam int DIV_WIDTH   = 16;
    localparam int RESET_DIV   = 7;
    localparam int NUM_ENTRIES = 8;

    logic      clk;
    logic      rst;
    logic      wr_en;
    logic      rd_en;
    reg_addr_t addr;
    reg_data_t wdata;
    reg_data_t rdata;
    logic      rd_valid;
    seg_t      seg;
    anode_t    an;

    // Register model
    hex_word_t  model_value;
    logic [3:0] model_en;
    reg_data_t  model_div;

    // Stimulus table
    hex_word_t  tbl_value [NUM_ENTRIES];
    logic [3:0] tbl_en    [NUM_ENTRIES];
    reg_data_t  tbl_div   [NUM_ENTRIES];

    int unsigned lcg_state   = 95986;
    int          error_count = 0;

    display_top #(
        .DIV_WIDTH (DIV_WIDTH),
        .RESET_DIV (RESET_DIV)
    ) uut (
        .clk      (clk),
        .rst      (rst),
        .wr_en    (wr_en),
        .rd_en    (rd_en),
        .addr     (addr),
        .wdata    (wdata),
        .rdata    (rdata),
        .rd_valid (rd_valid),
        .seg      (seg),
        .an       (an)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic stop_with_error(input string msg);
        error_count++;
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "Stopping at first error");
    endtask

    task automatic check_seg(input seg_t got, input seg_t exp, input string what);
        if (got !== exp)
            stop_with_error($sformatf("FAIL %0d ns: %s seg %b expected %b",
                                      $time, what, got, exp));
    endtask

    task automatic check_anode(input anode_t got, input anode_t exp, input string what);
        if (got !== exp)
            stop_with_error($sformatf("FAIL %0d ns: %s an %b expected %b",
                                      $time, what, got, exp));
    endtask

    task automatic check_data(input reg_data_t got, input reg_data_t exp, input string what);
        if (got !== exp)
            stop_with_error($sformatf("FAIL %0d ns: %s %h expected %h",
                                      $time, what, got, exp));
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp)
            stop_with_error($sformatf("FAIL %0d ns: %s %0d expected %0d",
                                      $time, what, got, exp));
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp)
            stop_with_error($sformatf("FAIL %0d ns: %s %b expected %b",
                                      $time, what, got, exp));
    endtask

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // Active-high font, bit 0 = a
    function automatic logic [6:0] lit_segments(input nibble_t hex);
        case (hex)
            4'h0: return 7'h3F;
            4'h1: return 7'h06;
            4'h2: return 7'h5B;
            4'h3: return 7'h4F;
            4'h4: return 7'h66;
            4'h5: return 7'h6D;
            4'h6: return 7'h7D;
            4'h7: return 7'h07;
            4'h8: return 7'h7F;
            4'h9: return 7'h6F;
            4'hA: return 7'h77;
            4'hB: return 7'h7C;
            4'hC: return 7'h39;
            4'hD: return 7'h5E;
            4'hE: return 7'h79;
            default: return 7'h71;
        endcase
    endfunction

    function automatic seg_t expected_seg(input digit_sel_t d);
        if (!model_en[d])
            return 7'b1111111;
        return ~lit_segments(model_value[4*d +: 4]);  // Pins are low-active
    endfunction

    function automatic reg_data_t model_read(input reg_addr_t a);
        case (a)
            addr_value:   return model_value;
            addr_enable:  return {12'h000, model_en};
            addr_divider: return model_div & reg_data_t'((1 << DIV_WIDTH) - 1);
            default:      return '0;
        endcase
    endfunction

    task automatic update_model(input reg_addr_t a, input reg_data_t d);
        case (a)
            addr_value:   model_value = d;
            addr_enable:  model_en = d[3:0];
            addr_divider: model_div = d & reg_data_t'((1 << DIV_WIDTH) - 1);
            default:      ;
        endcase
    endtask

    task automatic set_entry(input int i, input hex_word_t v, input logic [3:0] e,
                             input reg_data_t d);
        tbl_value[i] = v;
        tbl_en[i]    = e;
        tbl_div[i]   = d;
    endtask

    task automatic write_reg(input reg_addr_t a, input reg_data_t d);
        @(posedge clk);
        wr_en <= 1'b1;
        addr  <= a;
        wdata <= d;
        @(posedge clk);
        wr_en <= 1'b0;
        update_model(a, d);
    endtask

    // Waits for the read pulse, checks latency, data and that the pulse is one cycle long
    task automatic wait_read_data(input reg_data_t exp);
        int n;
        n = 0;
        @(negedge clk);
        while (rd_valid !== 1'b1) begin
            n++;
            if (n > 8)
                stop_with_error("Timeout: read strobe gave no rd_valid");
            @(negedge clk);
        end
        check_count(n + 1, 1, "read latency in cycles");
        check_data(rdata, exp, "read data");
        @(negedge clk);
        check_flag(rd_valid, 1'b0, "rd_valid second cycle");
    endtask

    task automatic read_reg(input reg_addr_t a);
        reg_data_t exp;
        exp = model_read(a);
        @(posedge clk);
        rd_en <= 1'b1;
        addr  <= a;
        @(posedge clk);
        rd_en <= 1'b0;
        wait_read_data(exp);
    endtask

    // Write and read the same register on one edge, old contents come back
    task automatic write_and_read(input reg_addr_t a, input reg_data_t d);
        reg_data_t exp;
        exp = model_read(a);
        @(posedge clk);
        wr_en <= 1'b1;
        rd_en <= 1'b1;
        addr  <= a;
        wdata <= d;
        @(posedge clk);
        wr_en <= 1'b0;
        rd_en <= 1'b0;
        update_model(a, d);
        wait_read_data(exp);
    endtask

    task automatic wait_anode_edge(input int limit);
        anode_t held;
        int     n;
        held = an;
        n = 0;
        while (an === held) begin
            @(negedge clk);
            n++;
            if (n > limit)
                stop_with_error("Timeout: anode pattern did not change");
        end
    endtask

    // Skip two digit boundaries, then check five dwells for order, segments and length
    task automatic observe_scan(input int first_limit);
        digit_sel_t d;
        anode_t     held;
        anode_t     exp_an;
        int         count;
        int         k;
        wait_anode_edge(first_limit);
        wait_anode_edge(int'(model_div) + 10);
        d = 2'd0;
        for (k = 0; k < 4; k++)
            if (an[k] === 1'b0)
                d = digit_sel_t'(k);
        for (k = 0; k < 5; k++) begin
            exp_an = 4'b1111;
            exp_an[d] = 1'b0;
            check_anode(an, exp_an, "scan order");
            held = an;
            count = 0;
            while (an === held) begin
                check_seg(seg, expected_seg(d), $sformatf("digit %0d", d));
                count++;
                if (count > int'(model_div) + 10)
                    stop_with_error("Timeout: digit never released its anode");
                @(negedge clk);
            end
            check_count(count, int'(model_div) + 1, "dwell length");
            d = d + 1'b1;
        end
    endtask

    initial begin
        reg_data_t   old_div;
        int unsigned r;
        int          i;

        rst   = 1'b1;
        wr_en = 1'b0;
        rd_en = 1'b0;
        addr  = '0;
        wdata = '0;
        model_value = '0;
        model_en    = 4'b1111;
        model_div   = reg_data_t'(RESET_DIV);

        set_entry(0, 16'h0123, 4'b1111, 16'd3);
        set_entry(1, 16'h4567, 4'b1111, 16'd0);
        set_entry(2, 16'h89AB, 4'b1111, 16'd5);
        set_entry(3, 16'hCDEF, 4'b1111, 16'd2);
        set_entry(4, 16'hF00F, 4'b0101, 16'd4);
        set_entry(5, 16'h8888, 4'b0000, 16'd1);
        r = lcg_next();
        set_entry(6, r[31:16], r[11:8], reg_data_t'(r[7:0] % 8));
        r = lcg_next();
        set_entry(7, r[31:16], r[11:8], reg_data_t'(r[7:0] % 8));

        for (i = 0; i < 15; i++) begin
            @(posedge clk);
            @(negedge clk);
            check_anode(an, 4'b1111, "reset");
            check_seg(seg, 7'b1111111, "reset");
            check_flag(rd_valid, 1'b0, "rd_valid in reset");
        end
        @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_anode(an, 4'b1111, "cycle after reset");
        check_seg(seg, 7'b1111111, "cycle after reset");
        @(negedge clk);
        check_anode(an, 4'b1110, "first digit after reset");

        // Reset contents, then each address
        read_reg(addr_value);
        read_reg(addr_enable);
        read_reg(addr_divider);
        write_reg(addr_value, 16'hBEEF);
        read_reg(addr_value);
        write_reg(addr_enable, 16'hFFF5);
        read_reg(addr_enable);
        write_reg(addr_divider, 16'h0009);
        read_reg(addr_divider);
        write_reg(2'd3, 16'hAAAA);
        read_reg(2'd3);
        write_and_read(addr_value, 16'h1234);
        read_reg(addr_value);

        for (i = 0; i < NUM_ENTRIES; i++) begin
            old_div = model_div;
            write_reg(addr_value, tbl_value[i]);
            write_reg(addr_enable, reg_data_t'(tbl_en[i]));
            write_reg(addr_divider, tbl_div[i]);
            read_reg(addr_value);
            read_reg(addr_enable);
            read_reg(addr_divider);
            observe_scan(int'(old_div) + int'(model_div) + 10);
        end

        if (error_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
src/sevenseg_pkg.sv
src/display_regs.sv
src/hex_display.sv
src/display_top.sv
tests/display_assert.sv
tests/display_tb.sv

// ==== Bender.yml ====
package:
  name: sevenseg_display

sources:
  - files:
      - src/sevenseg_pkg.sv
      - src/display_regs.sv
      - src/hex_display.sv
      - src/display_top.sv
  - target: test
    files:
      - tests/display_assert.sv
      - tests/display_tb.sv
